// ==== src.f ====
+incdir+include
hw/core_pkg.sv
hw/wb_slave_port.sv
hw/id.sv
hw/gpr.sv
hw/ex.sv
hw/int_core_top.sv
bench/tb_int_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RV32I slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module tb_int_core -o sim_int_core

out=$(./obj_dir/sim_int_core)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi

// ==== bench/tb_int_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module tb_int_core;

    // about 290 transactions of at most 5 cycles each, with wide margin
    localparam int MAX_CYCLES = 3000;
    localparam int RESP_NONE  = 0;
    localparam int RESP_ACK   = 1;
    localparam int RESP_ERR   = 2;

    // r-type ops: add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] R_F3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                          3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic       R_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                          1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    // immediate ops: slti sltiu xori ori andi slli srli srai
    localparam logic [2:0] I_F3  [8]  = '{3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    localparam logic       I_ALT [8]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic                       clk;
    logic                       rst_i;
    logic                       cyc_i;
    logic                       stb_i;
    logic                       we_i;
    logic [`WB_ADR_WIDTH-1:0]   adr_i;
    logic [`REG_DATA_WIDTH-1:0] dat_i;
    logic [`REG_DATA_WIDTH-1:0] dat_o;
    logic                       ack_o;
    logic                       err_o;

    // reference register file
    logic [`REG_DATA_WIDTH-1:0] model [`REG_NUM];
    int                         errors;
    int                         checks;
    int                         tests;
    int                         cycles;

    int_core_top dut0 (
        .clk   (clk),
        .rst_i (rst_i),
        .cyc_i (cyc_i),
        .stb_i (stb_i),
        .we_i  (we_i),
        .adr_i (adr_i),
        .dat_i (dat_i),
        .dat_o (dat_o),
        .ack_o (ack_o),
        .err_o (err_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] r_word(input logic alt, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // rv32i alu rules, alt picks sub over add and sra over srl
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            // signs differ: the negative one is smaller
            3'd2:    return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            // sign bit fills the vacated upper bits
            3'd5:    return alt ? ((a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}}))
                                : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            RESP_ACK: return "ack";
            RESP_ERR: return "err";
            default:  return "no response";
        endcase
    endfunction

    // one classic cycle, inputs change on the falling edge
    task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] wdata,
                             output int resp, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = we;
        adr_i = adr;
        dat_i = wdata;
        resp   = RESP_NONE;
        waited = 0;
        // response sampled mid-cycle, up to 4 cycles
        while (resp == RESP_NONE && waited < 4) begin
            @(negedge clk);
            waited++;
            if (ack_o) begin
                resp = RESP_ACK;
            end else if (err_o) begin
                resp = RESP_ERR;
            end
        end
        rdata = dat_o;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [31:0] data, output int resp);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, resp, unused);
    endtask

    // register space sits above bit 5
    task automatic wb_read(input logic [4:0] idx, output int resp, output logic [31:0] data);
        bus_cycle(1'b0, {1'b1, idx}, 32'd0, resp, data);
    endtask

    task automatic check_resp(input string name, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("%s: DUT gave %s where %s was expected", name, kind_name(got),
                     kind_name(exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] idx);
        int          resp;
        logic [31:0] data;
        wb_read(idx, resp, data);
        check_resp(name, RESP_ACK, resp);
        checks++;
        assert (data === model[idx]) else begin
            errors++;
            $display("error %s x%0d: expected %h, actual %h", name, idx, model[idx], data);
        end
    endtask

    task automatic check_all(input string name);
        for (int i = 0; i < `REG_NUM; i++) begin
            check_reg(name, 5'(i));
        end
    endtask

    // send one legal word and update the model
    task automatic run_instr(input string name, input logic [31:0] instr);
        int          resp;
        logic        is_r;
        logic [31:0] a;
        logic [31:0] b;
        wb_write(6'd0, instr, resp);
        check_resp(name, RESP_ACK, resp);
        is_r = (instr[6:0] == 7'b0110011);
        a = model[instr[19:15]];
        b = is_r ? model[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        // addi has no alt form, srai carries it in imm[10]
        if (instr[11:7] != 5'd0) begin
            model[instr[11:7]] = alu_ref(instr[14:12],
                                         instr[30] && (is_r || instr[14:12] == 3'd5), a, b);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %-8s %s, %0d errors", name,
                 (errors == errs_before) ? "passed" : "failed", errors - errs_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        checks++;
        assert (!ack_o && !err_o) else begin
            errors++;
            $display("reset: ack or err is high right after reset");
        end
        check_all("reset");
        end_test("reset", e0);
    endtask

    task automatic test_addi_chain();
        int         e0;
        logic [4:0] rs1;
        e0 = errors;
        // each register builds on an earlier one
        for (int r = 1; r < `REG_NUM; r++) begin
            rs1 = 5'($urandom_range(r - 1, 0));
            run_instr("addi", i_word(12'($urandom), 3'd0, 5'(r), rs1));
        end
        check_all("addi");
        end_test("addi", e0);
    endtask

    task automatic test_rtype();
        int         e0;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        e0 = errors;
        // fixed negative operand for sra and slt vs sltu
        run_instr("rtype", i_word(12'h800, 3'd0, 5'd1, 5'd0));
        run_instr("rtype", i_word(12'd5, 3'd0, 5'd3, 5'd0));
        run_instr("rtype", r_word(1'b1, 3'd5, 5'd2, 5'd1, 5'd3));
        run_instr("rtype", r_word(1'b0, 3'd2, 5'd4, 5'd1, 5'd3));
        run_instr("rtype", r_word(1'b0, 3'd3, 5'd5, 5'd1, 5'd3));
        for (int i = 1; i < 6; i++) begin
            check_reg("rtype", 5'(i));
        end
        for (int n = 0; n < 30; n++) begin
            rd  = 5'($urandom_range(31, 1));
            rs1 = 5'($urandom_range(31, 1));
            rs2 = 5'($urandom_range(31, 1));
            run_instr("rtype", r_word(R_ALT[n % 10], R_F3[n % 10], rd, rs1, rs2));
            check_reg("rtype", rd);
        end
        end_test("rtype", e0);
    endtask

    task automatic test_itype();
        int          e0;
        int          k;
        logic [11:0] imm;
        logic [4:0]  rd;
        e0 = errors;
        for (int n = 0; n < 24; n++) begin
            k   = n % 8;
            imm = 12'($urandom);
            // shifts carry funct7 in the upper immediate bits
            if (I_F3[k] == 3'd1 || I_F3[k] == 3'd5) begin
                imm = {1'b0, I_ALT[k], 5'd0, imm[4:0]};
            end
            rd = 5'($urandom_range(31, 1));
            run_instr("itype", i_word(imm, I_F3[k], rd, 5'($urandom_range(31, 1))));
            check_reg("itype", rd);
        end
        end_test("itype", e0);
    endtask

    task automatic test_x0_dest();
        int e0;
        e0 = errors;
        run_instr("x0", i_word(12'h123, 3'd0, 5'd0, 5'd7));
        run_instr("x0", r_word(1'b0, 3'd6, 5'd0, 5'd3, 5'd9));
        // x0 stays zero and no other register picks up the result
        check_all("x0");
        end_test("x0", e0);
    endtask

    task automatic test_illegal();
        int          e0;
        int          resp;
        logic [31:0] bad [5];
        e0 = errors;
        // lw, mul, xor with alt funct7, slli with alt funct7, all zero
        bad[0] = {12'h004, 5'd1, 3'b010, 5'd2, 7'b0000011};
        bad[1] = {7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011};
        bad[2] = r_word(1'b1, 3'd4, 5'd3, 5'd1, 5'd2);
        bad[3] = i_word({7'b0100000, 5'd3}, 3'd1, 5'd4, 5'd1);
        bad[4] = 32'd0;
        for (int i = 0; i < 5; i++) begin
            wb_write(6'd0, bad[i], resp);
            check_resp("illegal", RESP_ERR, resp);
        end
        // register space is read only
        wb_write({1'b1, 5'd6}, $urandom, resp);
        check_resp("illegal", RESP_ERR, resp);
        check_all("illegal");
        end_test("illegal", e0);
    endtask

    initial begin
        rst_i  = 1'b1;
        cyc_i  = 1'b0;
        stb_i  = 1'b0;
        we_i   = 1'b0;
        adr_i  = '0;
        dat_i  = '0;
        errors = 0;
        checks = 0;
        tests  = 0;
        void'($urandom(99621));
        for (int i = 0; i < `REG_NUM; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        test_reset();
        test_addi_chain();
        test_rtype();
        test_itype();
        test_x0_dest();
        test_illegal();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/int_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module int_core_top (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       cyc_i,
    input  logic                       stb_i,
    input  logic                       we_i,
    input  logic [`WB_ADR_WIDTH-1:0]   adr_i,
    input  logic [`REG_DATA_WIDTH-1:0] dat_i,
    output logic [`REG_DATA_WIDTH-1:0] dat_o,
    output logic                       ack_o,
    output logic                       err_o
);

    // port <-> decoder
    logic [`REG_DATA_WIDTH-1:0] instr;
    logic                       illegal;
    logic                       issue;

    // decoder -> alu / register file
    logic                       valid;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_DATA_WIDTH-1:0] imm;
    logic                       use_imm;
    core_pkg::alu_op_e          alu_op;

    // register file data
    logic [`REG_DATA_WIDTH-1:0] rs1_data;
    logic [`REG_DATA_WIDTH-1:0] rs2_data;
    logic [`REG_ADDR_WIDTH-1:0] rb_addr;
    logic [`REG_DATA_WIDTH-1:0] rb_data;

    // alu write-back
    logic                       wb_we;
    logic [`REG_ADDR_WIDTH-1:0] wb_addr;
    logic [`REG_DATA_WIDTH-1:0] wb_data;

    wb_slave_port u_port (
        .clk       (clk),
        .rst_i     (rst_i),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .adr_i     (adr_i),
        .dat_i     (dat_i),
        .dat_o     (dat_o),
        .ack_o     (ack_o),
        .err_o     (err_o),
        .instr_o   (instr),
        .illegal_i (illegal),
        .issue_o   (issue),
        .rd_addr_o (rb_addr),
        .rd_data_i (rb_data)
    );

    id u_id (
        .clk       (clk),
        .rst_i     (rst_i),
        .instr_i   (instr),
        .issue_i   (issue),
        .illegal_o (illegal),
        .valid_o   (valid),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .imm_o     (imm),
        .use_imm_o (use_imm),
        .alu_op_o  (alu_op)
    );

    gpr u_gpr (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .raddr3_i (rb_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .rdata3_o (rb_data)
    );

    ex u_ex (
        .valid_i    (valid),
        .use_imm_i  (use_imm),
        .rd_i       (rd),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .alu_op_i   (alu_op),
        .we_o       (wb_we),
        .waddr_o    (wb_addr),
        .wdata_o    (wb_data)
    );

endmodule

`default_nettype wire

// ==== hw/ex.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module ex (
    input  logic                       valid_i,
    input  logic                       use_imm_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [`REG_DATA_WIDTH-1:0] imm_i,
    input  logic [`REG_DATA_WIDTH-1:0] rs1_data_i,
    input  logic [`REG_DATA_WIDTH-1:0] rs2_data_i,
    input  core_pkg::alu_op_e          alu_op_i,
    output logic                       we_o,
    output logic [`REG_ADDR_WIDTH-1:0] waddr_o,
    output logic [`REG_DATA_WIDTH-1:0] wdata_o
);

    logic [`REG_DATA_WIDTH-1:0] op_a;
    logic [`REG_DATA_WIDTH-1:0] op_b;
    logic [4:0]                 shamt;

    assign op_a  = rs1_data_i;
    // immediate form replaces rs2
    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    // shift amount from low bits only
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            core_pkg::ALU_ADD:  wdata_o = op_a + op_b;
            core_pkg::ALU_SUB:  wdata_o = op_a - op_b;
            core_pkg::ALU_SLL:  wdata_o = op_a << shamt;
            // signed compare
            core_pkg::ALU_SLT:  wdata_o = {31'd0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: wdata_o = {31'd0, op_a < op_b};
            core_pkg::ALU_XOR:  wdata_o = op_a ^ op_b;
            core_pkg::ALU_SRL:  wdata_o = op_a >> shamt;
            // arithmetic shift keeps sign
            core_pkg::ALU_SRA:  wdata_o = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_OR:   wdata_o = op_a | op_b;
            core_pkg::ALU_AND:  wdata_o = op_a & op_b;
            default:            wdata_o = '0;
        endcase
    end

    // write lands on the edge after issue
    assign we_o    = valid_i;
    assign waddr_o = rd_i;

endmodule

`default_nettype wire

// ==== hw/gpr.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module gpr (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       we_i,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`REG_DATA_WIDTH-1:0] wdata_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr3_i,
    output logic [`REG_DATA_WIDTH-1:0] rdata1_o,
    output logic [`REG_DATA_WIDTH-1:0] rdata2_o,
    output logic [`REG_DATA_WIDTH-1:0] rdata3_o
);

    logic [`REG_DATA_WIDTH-1:0] regs [0:`REG_NUM-1];
    logic [`REG_NUM-1:0]        reg_we;

    // x0 has no write enable
    assign reg_we[0] = 1'b0;

    for (genvar i = 1; i < `REG_NUM; i++) begin : gen_reg_we
        assign reg_we[i] = we_i && (waddr_i == `REG_ADDR_WIDTH'(i));
    end

    // one enable-flop per register, cleared on reset
    for (genvar i = 0; i < `REG_NUM; i++) begin : gen_regs
        always_ff @(posedge clk) begin
            if (rst_i) begin
                regs[i] <= '0;
            end else if (reg_we[i]) begin
                regs[i] <= wdata_i;
            end
        end
    end

    // operand reads, x0 forced to zero
    assign rdata1_o = (raddr1_i == `ZERO_REG) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == `ZERO_REG) ? '0 : regs[raddr2_i];

    // bus read-back
    assign rdata3_o = (raddr3_i == `ZERO_REG) ? '0 : regs[raddr3_i];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst_i)
        regs[0] == '0);

endmodule

`default_nettype wire

// ==== hw/id.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module id (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [`REG_DATA_WIDTH-1:0] instr_i,
    input  logic                       issue_i,
    output logic                       illegal_o,
    output logic                       valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_o,
    output logic [`REG_ADDR_WIDTH-1:0] rd_o,
    output logic [`REG_DATA_WIDTH-1:0] imm_o,
    output logic                       use_imm_o,
    output core_pkg::alu_op_e          alu_op_o
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    logic       is_op;
    core_pkg::alu_op_e alu_op;

    assign funct7  = instr_i[31:25];
    assign funct3  = instr_i[14:12];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign is_op   = (core_pkg::opcode_e'(instr_i[6:0]) == core_pkg::OPC_OP);

    // legality check on opcode/funct3/funct7
    always_comb begin
        case (core_pkg::opcode_e'(instr_i[6:0]))
            core_pkg::OPC_OP: begin
                // alt funct7 only for sub and sra
                illegal_o = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            core_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b001:  illegal_o = !f7_zero;
                    3'b101:  illegal_o = !(f7_zero || f7_alt);
                    // plain immediates, funct7 is part of imm
                    default: illegal_o = 1'b0;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase
    end

    // funct3 to alu op
    always_comb begin
        case (funct3)
            // addi never subtracts
            3'b000:  alu_op = (is_op && funct7[5]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  alu_op = core_pkg::ALU_SLL;
            3'b010:  alu_op = core_pkg::ALU_SLT;
            3'b011:  alu_op = core_pkg::ALU_SLTU;
            3'b100:  alu_op = core_pkg::ALU_XOR;
            3'b101:  alu_op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  alu_op = core_pkg::ALU_OR;
            default: alu_op = core_pkg::ALU_AND;
        endcase
    end

    // decoded fields held for the execute cycle
    always_ff @(posedge clk) begin
        if (issue_i) begin
            rs1_o     <= instr_i[19:15];
            rs2_o     <= instr_i[24:20];
            rd_o      <= instr_i[11:7];
            // sign-extended i-type immediate
            imm_o     <= {{20{instr_i[31]}}, instr_i[31:20]};
            use_imm_o <= !is_op;
            alu_op_o  <= alu_op;
        end
    end

    // execute strobe, one cycle after issue
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= issue_i;
        end
    end

    // bus handshake keeps issues at least two cycles apart
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst_i)
        valid_o |=> !valid_o);

endmodule

`default_nettype wire

// ==== hw/wb_slave_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module wb_slave_port (
    input  logic                       clk,
    input  logic                       rst_i,
    // wishbone classic slave
    input  logic                       cyc_i,
    input  logic                       stb_i,
    input  logic                       we_i,
    input  logic [`WB_ADR_WIDTH-1:0]   adr_i,
    input  logic [`REG_DATA_WIDTH-1:0] dat_i,
    output logic [`REG_DATA_WIDTH-1:0] dat_o,
    output logic                       ack_o,
    output logic                       err_o,
    // decoder side
    output logic [`REG_DATA_WIDTH-1:0] instr_o,
    input  logic                       illegal_i,
    output logic                       issue_o,
    // register read-back
    output logic [`REG_ADDR_WIDTH-1:0] rd_addr_o,
    input  logic [`REG_DATA_WIDTH-1:0] rd_data_i
);

    logic req_new;
    logic instr_wr;
    logic reg_wr;
    logic reg_rd;

    // new request only while no response is out
    // a held stb is not served twice
    assign req_new = cyc_i & stb_i & ~ack_o & ~err_o;

    // request kinds
    assign instr_wr = req_new & we_i & ~adr_i[`WB_REG_SEL_BIT];
    assign reg_wr   = req_new & we_i & adr_i[`WB_REG_SEL_BIT];
    assign reg_rd   = req_new & ~we_i;

    // write data is the instruction word
    assign instr_o = dat_i;

    // only legal words reach the decoder registers
    assign issue_o = instr_wr & ~illegal_i;

    // reads index the register file by the low address bits
    assign rd_addr_o = adr_i[`REG_ADDR_WIDTH-1:0];

    // one-cycle response flags
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            ack_o <= issue_o | reg_rd;
            // illegal word or write into register space
            err_o <= (instr_wr & illegal_i) | reg_wr;
        end
    end

    // read data, valid alongside ack
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            dat_o <= rd_data_i;
        end
    end

    // never ack and err together
    a_resp_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(ack_o && err_o));

    // a response follows a request sampled one edge earlier
    a_resp_req: assert property (@(posedge clk) disable iff (rst_i)
        (ack_o || err_o) |-> $past(cyc_i && stb_i));

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // major opcodes kept by this slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // alu operation, decoded from funct3/funct7
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_DATA_WIDTH 32
`define REG_NUM 32

// x0 index, always reads zero
`define ZERO_REG 5'd0

// wishbone word address width
`define WB_ADR_WIDTH 6

// address bit picking register space over instruction space
// 0 -> instruction write, 1 -> adr[4:0] is a register index
`define WB_REG_SEL_BIT 5

`endif
